// File: verif/pipeline_vectors.txt
# in:  pipe op we waddr src_a src_b byp_a byp_b br_a br_b rd wr type sext st_data
# exp: ex_d ex_we ex_wa mem_d mem_we mem_wa rvm_d rvm_we rvm_wa bdone btaken pc hz exr m1r mr r1 r2 r3 rr
# ALU with bypass from ex
0 0 1 1 10 20 0 0 0 0 0 0 0 0 0
30 1 1 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0
0 1 1 2 0 5 1 0 0 0 0 0 0 0 0
2b 1 2 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0
0 1 1 3 100 0 0 1 0 0 0 0 0 0 0
d5 1 3 0 0 0 0 0 0 0 0 0 0 3 0 0 0 0 0 0
0 1 1 4 0 100 1 0 0 0 0 0 0 0 0
ffffffd5 1 4 0 0 0 0 0 0 0 0 0 0 4 0 0 0 0 0 0
# Branches, taken then not taken
0 8 1 9 1000 40 0 0 7 7 0 0 0 0 0
0 0 0 0 0 0 0 0 0 1 1 1040 0 0 0 0 0 0 0 0
0 8 0 0 2000 fffffff0 0 0 7 8 0 0 0 0 0
0 0 0 0 0 0 0 0 0 1 0 1ff0 0 0 0 0 0 0 0 0
0 9 0 0 100 8 0 0 3 4 0 0 0 0 0
0 0 0 0 0 0 0 0 0 1 1 108 0 0 0 0 0 0 0 0
0 9 0 0 200 4 0 0 5 5 0 0 0 0 0
0 0 0 0 0 0 0 0 0 1 0 204 0 0 0 0 0 0 0 0
0 a 0 0 300 c 0 0 ffffffff 1 0 0 0 0 0
0 0 0 0 0 0 0 0 0 1 1 30c 0 0 0 0 0 0 0 0
0 a 0 0 400 10 0 0 5 fffffffe 0 0 0 0 0
0 0 0 0 0 0 0 0 0 1 0 410 0 0 0 0 0 0 0 0
# Word store, then sized loads
1 0 0 0 40 0 0 0 0 0 0 1 2 0 8badf00d
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 0 1 5 40 0 0 0 0 0 1 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 1 0 5 0 0 0 0 0
1 0 1 6 40 3 0 0 0 0 1 0 0 1 0
0 0 0 d 1 5 0 0 0 0 0 0 1 0 6 5 0 0 0 0
1 0 1 7 40 2 0 0 0 0 1 0 1 1 0
0 0 0 ffffff8b 1 6 0 0 0 0 0 0 1 0 7 6 0 0 0 0
1 0 1 8 40 0 0 0 0 0 1 0 1 0 0
0 0 0 ffff8bad 1 7 0 0 0 0 0 0 1 0 8 7 0 0 0 0
1 0 1 a 40 1 0 0 0 0 1 0 0 0 0
0 0 0 f00d 1 8 0 0 0 0 0 0 1 0 a 8 0 0 0 0
# No pipe, nothing may write
3 0 1 1f 0 0 0 0 0 0 1 0 0 0 0
0 0 0 f0 1 a 0 0 0 0 0 0 0 0 0 a 0 0 0 0
# Multiply pipeline
2 b 1 b 3 7 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 b 0 0 0
2 c 1 c ffffffff 2 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 c b 0 0
2 b 1 d fffffffd 5 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 d c b 0
2 c 1 e 40000000 8 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 15 1 b 0 0 0 0 0 0 0 e d c b
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 ffffffff 1 c 0 0 0 0 0 0 0 0 e d c
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 fffffff1 1 d 0 0 0 0 0 0 0 0 0 e d
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 2 1 e 0 0 0 0 0 0 0 0 0 0 e
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: exec_backend.f
common/exec_pkg.sv
common/mem_pkg.sv
ex_stage/ex_stage.sv
mem_pipeline/mem_pipeline.sv
rvm_pipeline/rvm_pipeline.sv
design/pipeline_wrapper.sv
verif/pipeline_wrapper_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the exec_backend testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module pipeline_wrapper_tb \
    -f exec_backend.f \
    -o sim_exec_backend

./obj_dir/sim_exec_backend > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// File: verif/pipeline_wrapper_tb.sv
module pipeline_wrapper_tb import exec_pkg::*, mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC = 64;
    localparam int N_IN    = 15;
    localparam int N_EXP   = 20;

    logic              clk_i;
    logic              rst_n_i;
    pipe_sel_e         pipe_i;
    alu_op_e           alu_op_i;
    logic              rf_we_i;
    logic [REG_AW-1:0] rf_waddr_i;
    logic [XLEN-1:0]   src_a_i;
    logic [XLEN-1:0]   src_b_i;
    bypass_sel_e       bypass_a_i;
    bypass_sel_e       bypass_b_i;
    logic [XLEN-1:0]   br_src_a_i;
    logic [XLEN-1:0]   br_src_b_i;
    logic              memop_rd_i;
    logic              memop_wr_i;
    memop_type_e       memop_type_i;
    logic              sign_ext_i;
    logic [XLEN-1:0]   st_data_i;

    logic [XLEN-1:0]   ex_data_o;
    logic              ex_we_o;
    logic [REG_AW-1:0] ex_waddr_o;
    logic [XLEN-1:0]   mem_data_o;
    logic              mem_we_o;
    logic [REG_AW-1:0] mem_waddr_o;
    logic [XLEN-1:0]   rvm_data_o;
    logic              rvm_we_o;
    logic [REG_AW-1:0] rvm_waddr_o;
    logic              branch_done_o;
    logic              branch_taken_o;
    logic [XLEN-1:0]   new_pc_o;
    logic              load_hazard_o;
    logic [REG_AW-1:0] ex_wreg_o;
    logic [REG_AW-1:0] mem1_wreg_o;
    logic [REG_AW-1:0] mem_wreg_o;
    logic [REG_AW-1:0] rvm1_wreg_o;
    logic [REG_AW-1:0] rvm2_wreg_o;
    logic [REG_AW-1:0] rvm3_wreg_o;
    logic [REG_AW-1:0] rvm_wreg_o;

    logic [XLEN-1:0] vin  [MAX_VEC][N_IN];
    logic [XLEN-1:0] vexp [MAX_VEC][N_EXP];
    int              num_vec;
    int              errors;
    string           where;

    pipeline_wrapper dut (.*);

    always #50 clk_i = ~clk_i;

    task automatic check_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s %s expected %h got %h", where, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_AW-1:0] got,
                             input logic [REG_AW-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s %s expected %h got %h", where, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s %s expected %h got %h", where, name, exp, got);
            errors++;
        end
    endtask

    // Comment lines start with a hash and input and expected lines alternate
    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        string body [$];
        fd = $fopen("verif/pipeline_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vectors file verif/pipeline_vectors.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != 8'h23) begin
                body.push_back(line);
            end
        end
        $fclose(fd);
        if (body.size() % 2 != 0 || body.size() / 2 > MAX_VEC) begin
            $display("vectors file has an odd or too large number of data lines");
            errors++;
            return;
        end
        for (int i = 0; i < body.size() / 2; i++) begin
            n = $sscanf(body[2*i], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vin[i][0], vin[i][1], vin[i][2], vin[i][3], vin[i][4],
                        vin[i][5], vin[i][6], vin[i][7], vin[i][8], vin[i][9],
                        vin[i][10], vin[i][11], vin[i][12], vin[i][13], vin[i][14]);
            if (n != N_IN) begin
                $display("input line of vector %0d is short, %0d fields read", i, n);
                errors++;
                return;
            end
            n = $sscanf(body[2*i+1],
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vexp[i][0], vexp[i][1], vexp[i][2], vexp[i][3], vexp[i][4],
                        vexp[i][5], vexp[i][6], vexp[i][7], vexp[i][8], vexp[i][9],
                        vexp[i][10], vexp[i][11], vexp[i][12], vexp[i][13], vexp[i][14],
                        vexp[i][15], vexp[i][16], vexp[i][17], vexp[i][18], vexp[i][19]);
            if (n != N_EXP) begin
                $display("expected line of vector %0d is short, %0d fields read", i, n);
                errors++;
                return;
            end
        end
        num_vec = body.size() / 2;
    endtask

    task automatic drive_inputs(input int i);
        pipe_i       = pipe_sel_e'(vin[i][0][1:0]);
        alu_op_i     = alu_op_e'(vin[i][1][3:0]);
        rf_we_i      = vin[i][2][0];
        rf_waddr_i   = vin[i][3][REG_AW-1:0];
        src_a_i      = vin[i][4];
        src_b_i      = vin[i][5];
        bypass_a_i   = bypass_sel_e'(vin[i][6][1:0]);
        bypass_b_i   = bypass_sel_e'(vin[i][7][1:0]);
        br_src_a_i   = vin[i][8];
        br_src_b_i   = vin[i][9];
        memop_rd_i   = vin[i][10][0];
        memop_wr_i   = vin[i][11][0];
        memop_type_i = memop_type_e'(vin[i][12][1:0]);
        sign_ext_i   = vin[i][13][0];
        st_data_i    = vin[i][14];
    endtask

    // Data and address are only meaningful while the write enable is set
    task automatic check_outputs(input int i);
        int   issue;
        logic mul_we;
        where = $sformatf("vector %0d", i);
        check_flag("ex_we_o", ex_we_o, vexp[i][1][0]);
        if (vexp[i][1][0]) begin
            check_data("ex_data_o", ex_data_o, vexp[i][0]);
            check_reg("ex_waddr_o", ex_waddr_o, vexp[i][2][REG_AW-1:0]);
        end
        check_flag("mem_we_o", mem_we_o, vexp[i][4][0]);
        if (vexp[i][4][0]) begin
            check_data("mem_data_o", mem_data_o, vexp[i][3]);
            check_reg("mem_waddr_o", mem_waddr_o, vexp[i][5][REG_AW-1:0]);
        end
        check_flag("rvm_we_o", rvm_we_o, vexp[i][7][0]);
        if (vexp[i][7][0]) begin
            check_data("rvm_data_o", rvm_data_o, vexp[i][6]);
            check_reg("rvm_waddr_o", rvm_waddr_o, vexp[i][8][REG_AW-1:0]);
        end
        check_flag("branch_done_o", branch_done_o, vexp[i][9][0]);
        check_flag("branch_taken_o", branch_taken_o, vexp[i][10][0]);
        check_data("new_pc_o", new_pc_o, vexp[i][11]);
        check_flag("load_hazard_o", load_hazard_o, vexp[i][12][0]);
        check_reg("ex_wreg_o", ex_wreg_o, vexp[i][13][REG_AW-1:0]);
        check_reg("mem1_wreg_o", mem1_wreg_o, vexp[i][14][REG_AW-1:0]);
        check_reg("mem_wreg_o", mem_wreg_o, vexp[i][15][REG_AW-1:0]);
        check_reg("rvm1_wreg_o", rvm1_wreg_o, vexp[i][16][REG_AW-1:0]);
        check_reg("rvm2_wreg_o", rvm2_wreg_o, vexp[i][17][REG_AW-1:0]);
        check_reg("rvm3_wreg_o", rvm3_wreg_o, vexp[i][18][REG_AW-1:0]);
        check_reg("rvm_wreg_o", rvm_wreg_o, vexp[i][19][REG_AW-1:0]);
        // Multiply write retires RVM_STAGES edges after its issue
        issue  = 0;
        mul_we = 1'b0;
        if (i >= RVM_STAGES - 1) begin
            issue  = i - (RVM_STAGES - 1);
            mul_we = (vin[issue][0][1:0] == RVM_PIPE) && vin[issue][2][0];
        end
        check_flag("rvm_we_o", rvm_we_o, mul_we);
        if (mul_we) begin
            check_reg("rvm_waddr_o", rvm_waddr_o, vin[issue][3][REG_AW-1:0]);
        end
    endtask

    task automatic check_idle();
        where = "reset";
        check_flag("ex_we_o", ex_we_o, 1'b0);
        check_flag("mem_we_o", mem_we_o, 1'b0);
        check_flag("rvm_we_o", rvm_we_o, 1'b0);
        check_flag("branch_done_o", branch_done_o, 1'b0);
        check_flag("branch_taken_o", branch_taken_o, 1'b0);
        check_flag("load_hazard_o", load_hazard_o, 1'b0);
    endtask

    initial begin
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        pipe_i       = NO_PIPE;
        alu_op_i     = ALU_ADD;
        rf_we_i      = 1'b0;
        rf_waddr_i   = '0;
        src_a_i      = '0;
        src_b_i      = '0;
        bypass_a_i   = NO_BYPASS;
        bypass_b_i   = NO_BYPASS;
        br_src_a_i   = '0;
        br_src_b_i   = '0;
        memop_rd_i   = 1'b0;
        memop_wr_i   = 1'b0;
        memop_type_i = MEM_WORD;
        sign_ext_i   = 1'b0;
        st_data_i    = '0;
        errors       = 0;
        num_vec      = 0;
        load_vectors();
        if (errors == 0) begin
            repeat (2) begin
                @(negedge clk_i);
                check_idle();
            end
            rst_n_i = 1'b1;
            for (int i = 0; i < num_vec; i++) begin
                drive_inputs(i);
                @(negedge clk_i);
                check_outputs(i);
            end
        end
        $display("vectors run: %0d  errors: %0d", num_vec, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Run length is the vector count plus some margin for reset and drain
    initial begin
        wait (num_vec > 0);
        #((num_vec + 10) * 100);
        errors++;
        $display("watchdog expired before all vectors were applied, errors: %0d", errors);
        $display("tests failed");
        $finish;
    end

endmodule : pipeline_wrapper_tb

// File: design/pipeline_wrapper.sv
module pipeline_wrapper import exec_pkg::*, mem_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,

    // Decoded operation
    input  pipe_sel_e         pipe_i,
    input  alu_op_e           alu_op_i,
    input  logic              rf_we_i,
    input  logic [REG_AW-1:0] rf_waddr_i,
    input  logic [XLEN-1:0]   src_a_i,
    input  logic [XLEN-1:0]   src_b_i,
    input  bypass_sel_e       bypass_a_i,
    input  bypass_sel_e       bypass_b_i,
    input  logic [XLEN-1:0]   br_src_a_i,
    input  logic [XLEN-1:0]   br_src_b_i,
    input  logic              memop_rd_i,
    input  logic              memop_wr_i,
    input  memop_type_e       memop_type_i,
    input  logic              sign_ext_i,
    input  logic [XLEN-1:0]   st_data_i,

    // Results towards the register file
    output logic [XLEN-1:0]   ex_data_o,
    output logic              ex_we_o,
    output logic [REG_AW-1:0] ex_waddr_o,
    output logic [XLEN-1:0]   mem_data_o,
    output logic              mem_we_o,
    output logic [REG_AW-1:0] mem_waddr_o,
    output logic [XLEN-1:0]   rvm_data_o,
    output logic              rvm_we_o,
    output logic [REG_AW-1:0] rvm_waddr_o,

    output logic              branch_done_o,
    output logic              branch_taken_o,
    output logic [XLEN-1:0]   new_pc_o,

    // Hazard information for decode
    output logic              load_hazard_o,
    output logic [REG_AW-1:0] ex_wreg_o,
    output logic [REG_AW-1:0] mem1_wreg_o,
    output logic [REG_AW-1:0] mem_wreg_o,
    output logic [REG_AW-1:0] rvm1_wreg_o,
    output logic [REG_AW-1:0] rvm2_wreg_o,
    output logic [REG_AW-1:0] rvm3_wreg_o,
    output logic [REG_AW-1:0] rvm_wreg_o
);

    logic              ex_rf_we;
    logic [REG_AW-1:0] ex_rf_waddr;
    logic              mem_rf_we;
    logic [REG_AW-1:0] mem_rf_waddr;
    logic              mem_rd;
    logic              mem_wr;
    logic              rvm_rf_we;
    logic [REG_AW-1:0] rvm_rf_waddr;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;

    logic              mem1_we;
    logic [REG_AW-1:0] mem1_waddr;
    logic              rvm1_we;
    logic [REG_AW-1:0] rvm1_waddr;
    logic              rvm2_we;
    logic [REG_AW-1:0] rvm2_waddr;
    logic              rvm3_we;
    logic [REG_AW-1:0] rvm3_waddr;

    function automatic logic [XLEN-1:0] bypass_mux(
        input bypass_sel_e     sel,
        input logic [XLEN-1:0] raw,
        input logic [XLEN-1:0] ex_res,
        input logic [XLEN-1:0] mem_res,
        input logic [XLEN-1:0] rvm_res
    );
        case (sel)
            BY_EX:   return ex_res;
            BY_MEM:  return mem_res;
            BY_RVM:  return rvm_res;
            default: return raw;
        endcase
    endfunction

    // Only the selected unit gets a real write and the others carry a bubble
    always_comb begin
        ex_rf_we     = 1'b0;
        ex_rf_waddr  = '0;
        mem_rf_we    = 1'b0;
        mem_rf_waddr = '0;
        mem_rd       = 1'b0;
        mem_wr       = 1'b0;
        rvm_rf_we    = 1'b0;
        rvm_rf_waddr = '0;
        case (pipe_i)
            EX_PIPE: begin
                ex_rf_we    = rf_we_i;
                ex_rf_waddr = rf_waddr_i;
            end
            MEM_PIPE: begin
                mem_rf_we    = rf_we_i;
                mem_rf_waddr = rf_waddr_i;
                mem_rd       = memop_rd_i;
                mem_wr       = memop_wr_i;
            end
            RVM_PIPE: begin
                rvm_rf_we    = rf_we_i;
                rvm_rf_waddr = rf_waddr_i;
            end
            default: ;
        endcase
    end

    always_comb begin
        op_a = bypass_mux(bypass_a_i, src_a_i, ex_data_o, mem_data_o, rvm_data_o);
        op_b = bypass_mux(bypass_b_i, src_b_i, ex_data_o, mem_data_o, rvm_data_o);
    end

    ex_stage u_ex_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .alu_op_i       (alu_op_i),
        .src_a_i        (op_a),
        .src_b_i        (op_b),
        .br_src_a_i     (br_src_a_i),
        .br_src_b_i     (br_src_b_i),
        .rf_we_i        (ex_rf_we),
        .rf_waddr_i     (ex_rf_waddr),
        .res_o          (ex_data_o),
        .we_o           (ex_we_o),
        .waddr_o        (ex_waddr_o),
        .branch_done_o  (branch_done_o),
        .branch_taken_o (branch_taken_o),
        .new_pc_o       (new_pc_o)
    );

    mem_pipeline u_mem_pipeline (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .src_a_i        (op_a),
        .src_b_i        (op_b),
        .st_data_i      (st_data_i),
        .rd_i           (mem_rd),
        .wr_i           (mem_wr),
        .type_i         (memop_type_i),
        .sign_ext_i     (sign_ext_i),
        .rf_we_i        (mem_rf_we),
        .rf_waddr_i     (mem_rf_waddr),
        .res_o          (mem_data_o),
        .we_o           (mem_we_o),
        .waddr_o        (mem_waddr_o),
        .stage1_we_o    (mem1_we),
        .stage1_waddr_o (mem1_waddr),
        .load_hazard_o  (load_hazard_o)
    );

    rvm_pipeline u_rvm_pipeline (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .alu_op_i   (alu_op_i),
        .src_a_i    (op_a),
        .src_b_i    (op_b),
        .rf_we_i    (rvm_rf_we),
        .rf_waddr_i (rvm_rf_waddr),
        .res_o      (rvm_data_o),
        .we_o       (rvm_we_o),
        .waddr_o    (rvm_waddr_o),
        .s1_we_o    (rvm1_we),
        .s1_waddr_o (rvm1_waddr),
        .s2_we_o    (rvm2_we),
        .s2_waddr_o (rvm2_waddr),
        .s3_we_o    (rvm3_we),
        .s3_waddr_o (rvm3_waddr)
    );

    // In-flight destinations are zero when the stage holds no write
    assign ex_wreg_o   = ex_we_o  ? ex_waddr_o  : '0;
    assign mem1_wreg_o = mem1_we  ? mem1_waddr  : '0;
    assign mem_wreg_o  = mem_we_o ? mem_waddr_o : '0;
    assign rvm1_wreg_o = rvm1_we  ? rvm1_waddr  : '0;
    assign rvm2_wreg_o = rvm2_we  ? rvm2_waddr  : '0;
    assign rvm3_wreg_o = rvm3_we  ? rvm3_waddr  : '0;
    assign rvm_wreg_o  = rvm_we_o ? rvm_waddr_o : '0;

    // Units with different latencies must never retire to one register together
    property no_same_waddr_p(we_a, waddr_a, we_b, waddr_b);
        @(posedge clk_i) disable iff (!rst_n_i)
            !(we_a && we_b && (waddr_a == waddr_b));
    endproperty

    assert property (no_same_waddr_p(ex_we_o, ex_waddr_o, mem_we_o, mem_waddr_o))
        else $error("%m: ex and mem units write the same register");

    assert property (no_same_waddr_p(ex_we_o, ex_waddr_o, rvm_we_o, rvm_waddr_o))
        else $error("%m: ex and multiply units write the same register");

    assert property (no_same_waddr_p(mem_we_o, mem_waddr_o, rvm_we_o, rvm_waddr_o))
        else $error("%m: mem and multiply units write the same register");

endmodule : pipeline_wrapper

// File: rvm_pipeline/rvm_pipeline.sv
module rvm_pipeline import exec_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  alu_op_e           alu_op_i,
    input  logic [XLEN-1:0]   src_a_i,
    input  logic [XLEN-1:0]   src_b_i,
    input  logic              rf_we_i,
    input  logic [REG_AW-1:0] rf_waddr_i,
    output logic [XLEN-1:0]   res_o,
    output logic              we_o,
    output logic [REG_AW-1:0] waddr_o,
    output logic              s1_we_o,
    output logic [REG_AW-1:0] s1_waddr_o,
    output logic              s2_we_o,
    output logic [REG_AW-1:0] s2_waddr_o,
    output logic              s3_we_o,
    output logic [REG_AW-1:0] s3_waddr_o
);

    logic signed [XLEN-1:0]   s1_a_q;
    logic signed [XLEN-1:0]   s1_b_q;
    logic signed [XLEN+15:0]  pp_hi_q;
    logic signed [XLEN+16:0]  pp_lo_q;
    logic signed [2*XLEN-1:0] prod_q;
    logic [RVM_STAGES-1:0]    we_pipe;
    logic [REG_AW-1:0]        waddr_pipe [RVM_STAGES];
    logic [RVM_STAGES-2:0]    hi_pipe;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_a_q  <= '0;
            s1_b_q  <= '0;
            pp_hi_q <= '0;
            pp_lo_q <= '0;
            prod_q  <= '0;
            res_o   <= '0;
        end else begin
            s1_a_q  <= src_a_i;
            s1_b_q  <= src_b_i;
            // Split b into a signed upper half and an unsigned lower half
            pp_hi_q <= s1_a_q * $signed(s1_b_q[XLEN-1:16]);
            pp_lo_q <= s1_a_q * $signed({1'b0, s1_b_q[15:0]});
            prod_q  <= (pp_hi_q <<< 16) + pp_lo_q;
            res_o   <= hi_pipe[RVM_STAGES-2] ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];
        end
    end

    // Write enable, destination and high-word select ride along with the data
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            we_pipe <= '0;
            hi_pipe <= '0;
            for (int i = 0; i < RVM_STAGES; i++) begin
                waddr_pipe[i] <= '0;
            end
        end else begin
            we_pipe       <= {we_pipe[RVM_STAGES-2:0], rf_we_i};
            hi_pipe       <= {hi_pipe[RVM_STAGES-3:0], alu_op_i == ALU_MULH};
            waddr_pipe[0] <= rf_waddr_i;
            for (int i = 1; i < RVM_STAGES; i++) begin
                waddr_pipe[i] <= waddr_pipe[i-1];
            end
        end
    end

    assign s1_we_o    = we_pipe[0];
    assign s1_waddr_o = waddr_pipe[0];
    assign s2_we_o    = we_pipe[1];
    assign s2_waddr_o = waddr_pipe[1];
    assign s3_we_o    = we_pipe[2];
    assign s3_waddr_o = waddr_pipe[2];
    assign we_o       = we_pipe[RVM_STAGES-1];
    assign waddr_o    = waddr_pipe[RVM_STAGES-1];

endmodule : rvm_pipeline

// File: mem_pipeline/mem_pipeline.sv
module mem_pipeline import exec_pkg::*, mem_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic [XLEN-1:0]   src_a_i,
    input  logic [XLEN-1:0]   src_b_i,
    input  logic [XLEN-1:0]   st_data_i,
    input  logic              rd_i,
    input  logic              wr_i,
    input  memop_type_e       type_i,
    input  logic              sign_ext_i,
    input  logic              rf_we_i,
    input  logic [REG_AW-1:0] rf_waddr_i,
    output logic [XLEN-1:0]   res_o,
    output logic              we_o,
    output logic [REG_AW-1:0] waddr_o,
    output logic              stage1_we_o,
    output logic [REG_AW-1:0] stage1_waddr_o,
    output logic              load_hazard_o
);

    logic [XLEN-1:0]    addr;
    logic               s1_rd_q;
    logic               s1_wr_q;
    memop_type_e        s1_type_q;
    logic               s1_sext_q;
    logic [1:0]         s1_off_q;
    logic [DMEM_AW-1:0] s1_idx_q;
    logic [XLEN-1:0]    s1_data_q;
    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [XLEN-1:0]    rd_word;
    logic [XLEN-1:0]    shifted;
    logic [XLEN-1:0]    load_val;
    logic [3:0]         byte_en;
    logic [XLEN-1:0]    wr_word;

    assign addr = src_a_i + src_b_i;

    // Stage 1, address and operation
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_rd_q        <= 1'b0;
            s1_wr_q        <= 1'b0;
            s1_type_q      <= MEM_WORD;
            s1_sext_q      <= 1'b0;
            s1_off_q       <= '0;
            s1_idx_q       <= '0;
            s1_data_q      <= '0;
            stage1_we_o    <= 1'b0;
            stage1_waddr_o <= '0;
        end else begin
            s1_rd_q        <= rd_i;
            s1_wr_q        <= wr_i;
            s1_type_q      <= type_i;
            s1_sext_q      <= sign_ext_i;
            s1_off_q       <= addr[1:0];
            s1_idx_q       <= addr[DMEM_AW+1:2];
            s1_data_q      <= st_data_i;
            stage1_we_o    <= rf_we_i;
            stage1_waddr_o <= rf_waddr_i;
        end
    end

    assign load_hazard_o = s1_rd_q;

    // Store lanes follow the access size and the byte offset
    always_comb begin
        case (s1_type_q)
            MEM_BYTE: begin
                byte_en = 4'b0001 << s1_off_q;
                wr_word = {4{s1_data_q[7:0]}};
            end
            MEM_HALF: begin
                byte_en = 4'b0011 << s1_off_q;
                wr_word = {2{s1_data_q[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wr_word = s1_data_q;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (s1_wr_q) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    dmem[s1_idx_q][8*i +: 8] <= wr_word[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        rd_word = dmem[s1_idx_q];
        shifted = rd_word >> {s1_off_q, 3'b000};
        case (s1_type_q)
            MEM_BYTE: load_val = {{(XLEN-8){s1_sext_q & shifted[7]}}, shifted[7:0]};
            MEM_HALF: load_val = {{(XLEN-16){s1_sext_q & shifted[15]}}, shifted[15:0]};
            default:  load_val = rd_word;
        endcase
    end

    // Stage 2, sized load result
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_o   <= '0;
            we_o    <= 1'b0;
            waddr_o <= '0;
        end else begin
            res_o   <= s1_rd_q ? load_val : '0;
            we_o    <= stage1_we_o;
            waddr_o <= stage1_waddr_o;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(rd_i && wr_i))
        else $error("%m: load and store issued together");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     ((rd_i || wr_i) && type_i == MEM_HALF) |-> !addr[0])
        else $error("%m: misaligned half-word access");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     ((rd_i || wr_i) && type_i == MEM_WORD) |-> (addr[1:0] == 2'b00))
        else $error("%m: misaligned word access");

endmodule : mem_pipeline

// File: ex_stage/ex_stage.sv
module ex_stage import exec_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  alu_op_e           alu_op_i,
    input  logic [XLEN-1:0]   src_a_i,
    input  logic [XLEN-1:0]   src_b_i,
    input  logic [XLEN-1:0]   br_src_a_i,
    input  logic [XLEN-1:0]   br_src_b_i,
    input  logic              rf_we_i,
    input  logic [REG_AW-1:0] rf_waddr_i,
    output logic [XLEN-1:0]   res_o,
    output logic              we_o,
    output logic [REG_AW-1:0] waddr_o,
    output logic              branch_done_o,
    output logic              branch_taken_o,
    output logic [XLEN-1:0]   new_pc_o
);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] alu_res;
    logic            is_branch;
    logic            br_cond;

    // Shared by ADD and the branch target pc plus offset
    assign sum = src_a_i + src_b_i;

    always_comb begin
        alu_res   = '0;
        is_branch = 1'b0;
        br_cond   = 1'b0;
        case (alu_op_i)
            ALU_ADD: alu_res = sum;
            ALU_SUB: alu_res = src_a_i - src_b_i;
            ALU_AND: alu_res = src_a_i & src_b_i;
            ALU_OR:  alu_res = src_a_i | src_b_i;
            ALU_XOR: alu_res = src_a_i ^ src_b_i;
            ALU_SLL: alu_res = src_a_i << src_b_i[4:0];
            ALU_SRL: alu_res = src_a_i >> src_b_i[4:0];
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(src_a_i) < $signed(src_b_i)};
            ALU_BEQ: begin
                is_branch = 1'b1;
                br_cond   = (br_src_a_i == br_src_b_i);
            end
            ALU_BNE: begin
                is_branch = 1'b1;
                br_cond   = (br_src_a_i != br_src_b_i);
            end
            ALU_BLT: begin
                is_branch = 1'b1;
                br_cond   = ($signed(br_src_a_i) < $signed(br_src_b_i));
            end
            // Multiplies are done in the multiply unit
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_o          <= '0;
            we_o           <= 1'b0;
            waddr_o        <= '0;
            branch_done_o  <= 1'b0;
            branch_taken_o <= 1'b0;
            new_pc_o       <= '0;
        end else begin
            res_o          <= alu_res;
            we_o           <= rf_we_i && !is_branch;
            waddr_o        <= rf_waddr_i;
            branch_done_o  <= is_branch;
            branch_taken_o <= is_branch && br_cond;
            new_pc_o       <= is_branch ? sum : '0;
        end
    end

endmodule : ex_stage

// File: common/mem_pkg.sv
package mem_pkg;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } memop_type_e;

    // Local data RAM, word organised
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

endpackage : mem_pkg

// File: common/exec_pkg.sv
package exec_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // Issue to result latency of the multiply unit
    localparam int RVM_STAGES = 4;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_MUL,
        ALU_MULH
    } alu_op_e;

    typedef enum logic [1:0] {
        EX_PIPE,
        MEM_PIPE,
        RVM_PIPE,
        NO_PIPE
    } pipe_sel_e;

    // Operand source for the bypass network
    typedef enum logic [1:0] {
        NO_BYPASS,
        BY_EX,
        BY_MEM,
        BY_RVM
    } bypass_sel_e;

endpackage : exec_pkg
